// File: rtl/mem_geom_pkg.sv
package mem_geom_pkg;

	// byte address as seen by the subsystem, only the bits that pick a line and a byte in it
	localparam int ADDR_W = 12;
	localparam int LINE_W = 128;
	localparam int WORD_W = 32;
	localparam int BYTE_W = 8;

	// line index comes from the upper address bits
	localparam int INDEX_W = 8;
	localparam int LINE_COUNT = 256;

	// byte offset inside a line sits below the index
	localparam int OFFSET_W = ADDR_W - INDEX_W;

	// lowest address bit of the word lane select, bits below it pick a byte in the word
	localparam int WORD_SEL_LSB = $clog2(WORD_W / BYTE_W);

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [LINE_W-1:0] line_t;
	typedef logic [WORD_W-1:0] word_t;
	typedef logic [INDEX_W-1:0] index_t;

endpackage

// File: rtl/mem_req_pkg.sv
package mem_req_pkg;

	// entries per request queue
	localparam int QUEUE_DEPTH = 4;

	// a line read only needs the address, the response returns it unchanged
	typedef struct packed {
		mem_geom_pkg::addr_t addr;
	} rd_req_t;

	// is_byte selects a byte write at addr[3:0], otherwise a word write at addr[3:2]
	typedef struct packed {
		mem_geom_pkg::addr_t addr;
		mem_geom_pkg::word_t data;
		logic                is_byte;
	} wr_req_t;

endpackage

// File: rtl/line_port_if.sv
`timescale 1ns/1ps

interface line_port_if;
	import mem_geom_pkg::*;

	// read side, rd_line follows rd_en by one cycle
	logic   rd_en;
	index_t rd_idx;
	line_t  rd_line;

	// write side, takes effect at the clock edge
	logic   wr_en;
	index_t wr_idx;
	line_t  wr_line;

	// high once the clear sweep after reset has finished
	logic   init_done;

	modport ctrl (
		output rd_en,
		output rd_idx,
		output wr_en,
		output wr_idx,
		input  init_done
	);

	modport merge (
		input  rd_line,
		output wr_line
	);

	modport store (
		input  rd_en,
		input  rd_idx,
		input  wr_en,
		input  wr_idx,
		input  wr_line,
		output rd_line,
		output init_done
	);

endinterface

// File: rtl/req_fifo.sv
`timescale 1ns/1ps

module req_fifo #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rst_i,
	input  logic     in_valid_i,
	output logic     in_ready_o,
	input  payload_t in_data_i,
	output logic     out_valid_o,
	input  logic     out_ready_i,
	output payload_t out_data_o
);
	import mem_req_pkg::*;

	localparam int PTR_W = $clog2(QUEUE_DEPTH);
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

	payload_t         slots [QUEUE_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             push;
	logic             pop;

	// pointers wrap explicitly so the depth need not be a power of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(QUEUE_DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign in_ready_o = (count != CNT_W'(QUEUE_DEPTH));
	assign out_valid_o = (count != '0);
	assign out_data_o = slots[rd_ptr];
	assign push = in_valid_i && in_ready_o;
	assign pop = out_valid_o && out_ready_i;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			// a push and a pop in the same cycle leave the count unchanged
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			slots[wr_ptr] <= in_data_i;
		end
	end

	// the pointers only meet when the queue is empty or exactly full
	a_no_overflow: assert property (@(posedge clk) disable iff (rst_i)
		(wr_ptr == rd_ptr) == (count == '0 || count == CNT_W'(QUEUE_DEPTH)));

endmodule

// File: rtl/line_store.sv
`timescale 1ns/1ps

module line_store (
	input logic        clk,
	input logic        rst_i,
	line_port_if.store port
);
	import mem_geom_pkg::*;

	line_t  lines [LINE_COUNT];
	line_t  rd_line_q;
	index_t clr_idx;
	logic   init_done_q;

	// after reset the counter walks every line once, one per cycle
	always_ff @(posedge clk) begin
		if (rst_i) begin
			clr_idx <= '0;
			init_done_q <= 1'b0;
		end else if (!init_done_q) begin
			clr_idx <= clr_idx + 1'b1;
			if (clr_idx == INDEX_W'(LINE_COUNT - 1)) begin
				init_done_q <= 1'b1;
			end
		end
	end

	// the sweep owns the write port until it is done
	always_ff @(posedge clk) begin
		if (!rst_i && !init_done_q) begin
			lines[clr_idx] <= '0;
		end else if (port.wr_en) begin
			lines[port.wr_idx] <= port.wr_line;
		end
	end

	// read register only moves on rd_en, so a held response keeps its line
	always_ff @(posedge clk) begin
		if (port.rd_en) begin
			rd_line_q <= lines[port.rd_idx];
		end
	end

	assign port.rd_line = rd_line_q;
	assign port.init_done = init_done_q;

	// the controller must stay off both ports until the sweep has cleared every line
	a_no_early_access: assert property (@(posedge clk) disable iff (rst_i)
		(port.wr_en || port.rd_en) |-> port.init_done);

endmodule

// File: rtl/write_merge.sv
`timescale 1ns/1ps

module write_merge (
	line_port_if.merge           port,
	input mem_req_pkg::wr_req_t  wr_req_i
);
	import mem_geom_pkg::*;

	logic [OFFSET_W-1:0]              byte_sel;
	logic [OFFSET_W-WORD_SEL_LSB-1:0] word_sel;
	line_t                            merged;

	// byte lane uses all offset bits, word lane drops the byte-in-word bits
	assign byte_sel = wr_req_i.addr[OFFSET_W-1:0];
	assign word_sel = wr_req_i.addr[OFFSET_W-1:WORD_SEL_LSB];

	// the old line comes from the read issued one cycle earlier
	always_comb begin
		merged = port.rd_line;
		if (wr_req_i.is_byte) begin
			merged[byte_sel*BYTE_W +: BYTE_W] = wr_req_i.data[BYTE_W-1:0];
		end else begin
			merged[word_sel*WORD_W +: WORD_W] = wr_req_i.data;
		end
	end

	assign port.wr_line = merged;

endmodule

// File: rtl/mem_ctrl.sv
`timescale 1ns/1ps

module mem_ctrl (
	input  logic                 clk,
	input  logic                 rst_i,
	line_port_if.ctrl            port,
	input  logic                 rd_q_valid_i,
	output logic                 rd_q_ready_o,
	input  mem_req_pkg::rd_req_t rd_q_data_i,
	input  logic                 wr_q_valid_i,
	output logic                 wr_q_ready_o,
	input  mem_req_pkg::wr_req_t wr_q_data_i,
	output logic                 wr_in_ready_o,
	output logic                 rsp_valid_o,
	input  logic                 rsp_ready_i,
	output mem_geom_pkg::addr_t  rsp_addr_o
);
	import mem_geom_pkg::*;

	// ST_WRITE is the second half of a read-modify-write, ST_READ holds a response
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WRITE,
		ST_READ
	} state_t;

	state_t state;
	state_t state_nxt;
	logic   can_issue;
	logic   issue_wr;
	logic   issue_rd;
	index_t wr_line_idx;
	index_t rd_line_idx;
	addr_t  rsp_addr_q;

	assign wr_line_idx = wr_q_data_i.addr[ADDR_W-1:OFFSET_W];
	assign rd_line_idx = rd_q_data_i.addr[ADDR_W-1:OFFSET_W];

	// a new line read may start from idle, or in the cycle the pending response is taken
	assign can_issue = port.init_done &&
		(state == ST_IDLE || (state == ST_READ && rsp_ready_i));

	// writes go first, a read only runs against an empty write queue
	assign issue_wr = can_issue && wr_q_valid_i;
	assign issue_rd = can_issue && !wr_q_valid_i && rd_q_valid_i;

	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE, ST_READ: begin
				if (issue_wr) begin
					state_nxt = ST_WRITE;
				end else if (issue_rd) begin
					state_nxt = ST_READ;
				end else if (state == ST_READ && rsp_ready_i) begin
					state_nxt = ST_IDLE;
				end
			end
			// back to idle so the next line read sees this write in the array
			ST_WRITE: state_nxt = ST_IDLE;
			default: state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state <= ST_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	always_ff @(posedge clk) begin
		if (issue_rd) begin
			rsp_addr_q <= rd_q_data_i.addr;
		end
	end

	// one line read serves both a queued read and the first half of a write
	assign port.rd_en = issue_wr || issue_rd;
	assign port.rd_idx = issue_wr ? wr_line_idx : rd_line_idx;

	// the merged line is written and the write request popped in the same cycle
	assign port.wr_en = (state == ST_WRITE);
	assign port.wr_idx = wr_line_idx;
	assign wr_q_ready_o = (state == ST_WRITE);

	assign rd_q_ready_o = issue_rd;

	// no new writes while a read waits, so none can overtake it
	assign wr_in_ready_o = port.init_done && !rd_q_valid_i;

	assign rsp_valid_o = (state == ST_READ);
	assign rsp_addr_o = rsp_addr_q;

	// a stalled response keeps its valid and address until the consumer takes it
	a_rsp_stable: assert property (@(posedge clk) disable iff (rst_i)
		rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_addr_o));

endmodule

// File: rtl/mem_subsys.sv
`timescale 1ns/1ps

module mem_subsys (
	input  logic                clk,
	input  logic                rst_i,
	input  logic                rd_valid_i,
	output logic                rd_ready_o,
	input  mem_geom_pkg::addr_t rd_addr_i,
	input  logic                wr_valid_i,
	output logic                wr_ready_o,
	input  mem_geom_pkg::addr_t wr_addr_i,
	input  mem_geom_pkg::word_t wr_data_i,
	input  logic                wr_byte_i,
	output logic                rsp_valid_o,
	input  logic                rsp_ready_i,
	output mem_geom_pkg::line_t rsp_line_o,
	output mem_geom_pkg::addr_t rsp_addr_o
);
	import mem_req_pkg::*;

	line_port_if line_port ();

	rd_req_t rd_in_req;
	rd_req_t rd_q_req;
	wr_req_t wr_in_req;
	wr_req_t wr_q_req;
	logic    rd_push;
	logic    rd_fifo_ready;
	logic    rd_q_valid;
	logic    rd_q_ready;
	logic    wr_push;
	logic    wr_fifo_ready;
	logic    wr_q_valid;
	logic    wr_q_ready;
	logic    wr_in_ready;

	assign rd_in_req = '{addr: rd_addr_i};
	assign wr_in_req = '{addr: wr_addr_i, data: wr_data_i, is_byte: wr_byte_i};

	// reads are held off until the clear sweep is over
	assign rd_push = rd_valid_i && line_port.init_done;
	assign rd_ready_o = rd_fifo_ready && line_port.init_done;

	// write acceptance also needs the controller's go-ahead
	assign wr_push = wr_valid_i && wr_in_ready;
	assign wr_ready_o = wr_fifo_ready && wr_in_ready;

	req_fifo #(.payload_t(rd_req_t)) rd_fifo_i (
		.clk         (clk),
		.rst_i       (rst_i),
		.in_valid_i  (rd_push),
		.in_ready_o  (rd_fifo_ready),
		.in_data_i   (rd_in_req),
		.out_valid_o (rd_q_valid),
		.out_ready_i (rd_q_ready),
		.out_data_o  (rd_q_req)
	);

	req_fifo #(.payload_t(wr_req_t)) wr_fifo_i (
		.clk         (clk),
		.rst_i       (rst_i),
		.in_valid_i  (wr_push),
		.in_ready_o  (wr_fifo_ready),
		.in_data_i   (wr_in_req),
		.out_valid_o (wr_q_valid),
		.out_ready_i (wr_q_ready),
		.out_data_o  (wr_q_req)
	);

	mem_ctrl ctrl_i (
		.clk           (clk),
		.rst_i         (rst_i),
		.port          (line_port),
		.rd_q_valid_i  (rd_q_valid),
		.rd_q_ready_o  (rd_q_ready),
		.rd_q_data_i   (rd_q_req),
		.wr_q_valid_i  (wr_q_valid),
		.wr_q_ready_o  (wr_q_ready),
		.wr_q_data_i   (wr_q_req),
		.wr_in_ready_o (wr_in_ready),
		.rsp_valid_o   (rsp_valid_o),
		.rsp_ready_i   (rsp_ready_i),
		.rsp_addr_o    (rsp_addr_o)
	);

	// merge works on the head of the write queue
	write_merge merge_i (
		.port     (line_port),
		.wr_req_i (wr_q_req)
	);

	line_store store_i (
		.clk   (clk),
		.rst_i (rst_i),
		.port  (line_port)
	);

	assign rsp_line_o = line_port.rd_line;

	// the store's read register must not move under a held response
	a_rsp_line_stable: assert property (@(posedge clk) disable iff (rst_i)
		rsp_valid_o && !rsp_ready_i |=> $stable(rsp_line_o));

endmodule

// File: bench/mem_checker.sv
`timescale 1ns/1ps

module mem_checker (
	input  logic                clk,
	input  logic                rst_i,
	input  logic                rd_ready_i,
	input  logic                wr_ready_i,
	input  logic                rsp_valid_i,
	input  logic                rsp_ready_i,
	input  mem_geom_pkg::line_t rsp_line_i,
	input  mem_geom_pkg::addr_t rsp_addr_i,
	input  logic                exp_valid_i,
	input  mem_geom_pkg::line_t exp_line_i,
	input  mem_geom_pkg::addr_t exp_addr_i,
	input  logic                end_i,
	output int                  err_count_o,
	output int                  taken_count_o,
	output logic                done_o
);
	import mem_geom_pkg::*;

	line_t exp_lines [$];
	addr_t exp_addrs [$];
	int    sweep_cycles = 0;
	int    errors = 0;
	int    taken = 0;
	logic  held = 1'b0;
	line_t held_line;
	addr_t held_addr;

	task automatic compare(input string name, input line_t got, input line_t want);
		if (got !== want) begin
			$display("CHECK FAILED at %0t: %s is %0h, expected %0h", $time, name, got, want);
			errors++;
		end
	endtask

	// all DUT values are sampled at the rising edge, before any of them move
	always @(posedge clk) begin
		if (rst_i) begin
			sweep_cycles = 0;
			held = 1'b0;
			done_o <= 1'b0;
		end else begin
			// nothing may be accepted or answered while the store is being cleared
			if (sweep_cycles < LINE_COUNT) begin
				compare("rd_ready_o", line_t'(rd_ready_i), '0);
				compare("wr_ready_o", line_t'(wr_ready_i), '0);
				compare("rsp_valid_o", line_t'(rsp_valid_i), '0);
				sweep_cycles++;
			end

			// a response left waiting last cycle must still be there unchanged
			if (held) begin
				compare("rsp_valid_o", line_t'(rsp_valid_i), line_t'(1'b1));
				compare("rsp_line_o", rsp_line_i, held_line);
				compare("rsp_addr_o", line_t'(rsp_addr_i), line_t'(held_addr));
			end
			held = rsp_valid_i && !rsp_ready_i;
			held_line = rsp_line_i;
			held_addr = rsp_addr_i;

			if (exp_valid_i) begin
				exp_lines.push_back(exp_line_i);
				exp_addrs.push_back(exp_addr_i);
			end

			if (rsp_valid_i && rsp_ready_i) begin
				taken++;
				if (exp_lines.size() == 0) begin
					$display("at %0t a response was taken with no read outstanding", $time);
					errors++;
				end else begin
					compare("rsp_addr_o", line_t'(rsp_addr_i), line_t'(exp_addrs.pop_front()));
					compare("rsp_line_o", rsp_line_i, exp_lines.pop_front());
				end
			end

			if (end_i && !done_o) begin
				if (exp_lines.size() != 0) begin
					$display("%0d accepted reads never got a response", exp_lines.size());
					errors++;
				end
				$display("checker summary: %0d responses taken, %0d errors", taken, errors);
				done_o <= 1'b1;
			end
		end
		err_count_o <= errors;
		taken_count_o <= taken;
	end

endmodule

// File: bench/tb_mem_subsys.sv
`timescale 1ns/1ps

module tb_mem_subsys;
	import mem_geom_pkg::*;
	import mem_req_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int SEED = 32'ha885;
	localparam int DIRECT_REQS = 16;
	localparam int RAND_REQS = 500;
	// 20 cycles for every request, on top of reset and the clear sweep
	localparam int LIMIT_CYCLES = (DIRECT_REQS + RAND_REQS) * 20 + LINE_COUNT + 2;

	logic    clk;
	logic    rst_i;
	logic    rd_valid_i;
	logic    rd_ready_o;
	addr_t   rd_addr_i;
	logic    wr_valid_i;
	logic    wr_ready_o;
	addr_t   wr_addr_i;
	word_t   wr_data_i;
	logic    wr_byte_i;
	logic    rsp_valid_o;
	logic    rsp_ready_i;
	line_t   rsp_line_o;
	addr_t   rsp_addr_o;
	logic    exp_valid;
	line_t   exp_line;
	addr_t   exp_addr;
	logic    end_req;
	logic    report_done;
	int      error_count;
	int      taken_count;

	line_t   model [LINE_COUNT];
	addr_t   rd_plan [$];
	wr_req_t wr_plan [$];
	addr_t   rd_cur;
	wr_req_t wr_cur;
	logic    rd_pend;
	logic    wr_pend;
	int      rd_accepted;
	int      valid_pct;
	int      rsp_ready_pct;

	mem_subsys mem_subsys_i (
		.clk         (clk),
		.rst_i       (rst_i),
		.rd_valid_i  (rd_valid_i),
		.rd_ready_o  (rd_ready_o),
		.rd_addr_i   (rd_addr_i),
		.wr_valid_i  (wr_valid_i),
		.wr_ready_o  (wr_ready_o),
		.wr_addr_i   (wr_addr_i),
		.wr_data_i   (wr_data_i),
		.wr_byte_i   (wr_byte_i),
		.rsp_valid_o (rsp_valid_o),
		.rsp_ready_i (rsp_ready_i),
		.rsp_line_o  (rsp_line_o),
		.rsp_addr_o  (rsp_addr_o)
	);

	mem_checker mem_checker_i (
		.clk           (clk),
		.rst_i         (rst_i),
		.rd_ready_i    (rd_ready_o),
		.wr_ready_i    (wr_ready_o),
		.rsp_valid_i   (rsp_valid_o),
		.rsp_ready_i   (rsp_ready_i),
		.rsp_line_i    (rsp_line_o),
		.rsp_addr_i    (rsp_addr_o),
		.exp_valid_i   (exp_valid),
		.exp_line_i    (exp_line),
		.exp_addr_i    (exp_addr),
		.end_i         (end_req),
		.err_count_o   (error_count),
		.taken_count_o (taken_count),
		.done_o        (report_done)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// the line index is the upper eight address bits
	function automatic int line_of(input addr_t addr);
		return int'(addr[11:4]);
	endfunction

	// byte writes hit byte addr[3:0], word writes hit word lane addr[3:2]
	function automatic void apply_write(input wr_req_t req);
		line_t line;
		line = model[line_of(req.addr)];
		if (req.is_byte) begin
			line[int'(req.addr[3:0]) * 8 +: 8] = req.data[7:0];
		end else begin
			line[int'(req.addr[3:2]) * 32 +: 32] = req.data;
		end
		model[line_of(req.addr)] = line;
	endfunction

	function automatic void plan_write(input addr_t addr, input word_t data, input logic is_byte);
		wr_plan.push_back('{addr: addr, data: data, is_byte: is_byte});
	endfunction

	// most addresses fall on eight lines so reads and writes collide often
	function automatic addr_t rand_addr();
		addr_t addr;
		addr = addr_t'($urandom);
		if ($urandom_range(3) != 0) begin
			addr[11:4] = 8'h40 | 8'($urandom_range(7));
		end
		return addr;
	endfunction

	function automatic void fill_random(input int count);
		for (int i = 0; i < count; i++) begin
			rd_plan.push_back(rand_addr());
			plan_write(rand_addr(), word_t'($urandom), 1'($urandom_range(1)));
		end
	endfunction

	// one clock of traffic, the handshakes seen are those of the cycle that just ended
	task automatic step();
		@(posedge clk);
		// a write taken in the same cycle as a read lands in the model first
		if (wr_pend && wr_ready_o) begin
			apply_write(wr_cur);
			wr_pend = 1'b0;
		end
		exp_valid <= 1'b0;
		if (rd_pend && rd_ready_o) begin
			exp_valid <= 1'b1;
			exp_line <= model[line_of(rd_cur)];
			exp_addr <= rd_cur;
			rd_accepted++;
			rd_pend = 1'b0;
		end
		if (!wr_pend && wr_plan.size() != 0 && $urandom_range(99) < valid_pct) begin
			wr_cur = wr_plan.pop_front();
			wr_pend = 1'b1;
		end
		if (!rd_pend && rd_plan.size() != 0 && $urandom_range(99) < valid_pct) begin
			rd_cur = rd_plan.pop_front();
			rd_pend = 1'b1;
		end
		wr_valid_i <= wr_pend;
		wr_addr_i <= wr_cur.addr;
		wr_data_i <= wr_cur.data;
		wr_byte_i <= wr_cur.is_byte;
		rd_valid_i <= rd_pend;
		rd_addr_i <= rd_cur;
		rsp_ready_i <= ($urandom_range(99) < rsp_ready_pct);
	endtask

	// runs until every planned request is taken and every read has been answered
	task automatic run_plans();
		while (rd_plan.size() != 0 || wr_plan.size() != 0 || rd_pend || wr_pend ||
			taken_count != rd_accepted) begin
			step();
		end
	endtask

	initial begin
		void'($urandom(SEED));
		clk = 1'b0;
		rst_i = 1'b1;
		rd_valid_i = 1'b0;
		rd_addr_i = '0;
		wr_valid_i = 1'b0;
		wr_addr_i = '0;
		wr_data_i = '0;
		wr_byte_i = 1'b0;
		rsp_ready_i = 1'b0;
		exp_valid = 1'b0;
		exp_line = '0;
		exp_addr = '0;
		end_req = 1'b0;
		rd_cur = '0;
		wr_cur = '0;
		rd_pend = 1'b0;
		wr_pend = 1'b0;
		rd_accepted = 0;
		valid_pct = 100;
		rsp_ready_pct = 100;
		for (int i = 0; i < LINE_COUNT; i++) begin
			model[i] = '0;
		end
		repeat (2) @(posedge clk);
		rst_i <= 1'b0;

		// these reads wait through the sweep and must come back as zero
		for (int i = 0; i < 4; i++) begin
			rd_plan.push_back(addr_t'($urandom));
		end
		run_plans();

		// word lanes follow address bits 3:2 whatever the two bits below say
		plan_write(12'h120, 32'h1111_0000, 1'b0);
		plan_write(12'h125, 32'h2222_0001, 1'b0);
		plan_write(12'h12a, 32'h3333_0002, 1'b0);
		plan_write(12'h12f, 32'h4444_0003, 1'b0);
		plan_write(12'h128, 32'hcafe_f00d, 1'b0);
		run_plans();
		rd_plan.push_back(12'h120);
		rd_plan.push_back(12'h12c);
		run_plans();

		// only the low data byte goes in, the upper bits are noise
		plan_write(12'h340, 32'hffff_ffa5, 1'b1);
		plan_write(12'h347, 32'h5a5a_003c, 1'b1);
		plan_write(12'h34b, 32'h1234_5677, 1'b1);
		plan_write(12'h34f, 32'h0000_00e1, 1'b1);
		run_plans();
		rd_plan.push_back(12'h344);
		run_plans();

		valid_pct = 60;
		rsp_ready_pct = 80;
		fill_random(RAND_REQS * 3 / 10);
		run_plans();

		// mostly stalled consumer
		rsp_ready_pct = 25;
		fill_random(RAND_REQS / 5);
		run_plans();

		@(posedge clk);
		end_req <= 1'b1;
		@(posedge clk);
		while (!report_done) begin
			@(posedge clk);
		end
		if (error_count == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	initial begin
		#(LIMIT_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles before all requests completed", LIMIT_CYCLES);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: src.f
rtl/mem_geom_pkg.sv
rtl/mem_req_pkg.sv
rtl/line_port_if.sv
rtl/req_fifo.sv
rtl/line_store.sv
rtl/write_merge.sv
rtl/mem_ctrl.sv
rtl/mem_subsys.sv
bench/mem_checker.sv
bench/tb_mem_subsys.sv

// File: Makefile
SIM       := verilator
TOP       := tb_mem_subsys
FILELIST  := src.f
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only -Wall --timing
BUILD     := obj_dir
LOG       := sim.log
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD)/V$(TOP): $(SRCS) $(FILELIST)
	$(SIM) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "TESTS PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(SIM) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
